/* vlog.f */
logic/icache_geometry_pkg.sv
logic/axi_read_pkg.sv
logic/icache_sram_if.sv
logic/icache_tag_if.sv
logic/icache_tag_store.sv
logic/icache_data_sram.sv
logic/icache_ctrl.sv
logic/icache_top.sv
verification/icache_axi_mem.sv
verification/icache_checker.sv
verification/icache_tb.sv

/* Makefile */
# Verilator build for the instruction cache testbench
VERILATOR  = verilator
TOP        = icache_tb
FILELIST   = vlog.f
BUILD_DIR  = obj_dir
LINT_FLAGS = --lint-only --timing -Wall
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
PASS_MSG   = test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* verification/icache_tb.sv */
`default_nettype none

module icache_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import icache_geometry_pkg::*;
    import axi_read_pkg::*;

    localparam int clk_half = 2;
    localparam int reset_cycles = 5;
    localparam int num_tests = 21;
    // two resets in the run
    localparam int cycle_limit = num_tests * 40 + 2 * reset_cycles;
    localparam logic [word_bits-1:0] content_key = 32'h5A5A_0000;

    typedef struct packed {
        logic                 rst;
        logic                 miss;
        logic [addr_bits-1:0] addr;
    } entry_t;

    // reset first, miss expected, fetch address
    // tags A B C D from 0x1000 to 0x4000 share set 5
    // set 0x45 sits in banks 2 and 3
    localparam entry_t stim_tbl [num_tests] = '{
        '{1'b0, 1'b1, 32'h0000_1050},   // A cold, way 0
        '{1'b0, 1'b0, 32'h0000_1050},
        '{1'b0, 1'b0, 32'h0000_1054},   // rest of the line
        '{1'b0, 1'b0, 32'h0000_1058},
        '{1'b0, 1'b0, 32'h0000_105C},
        '{1'b0, 1'b1, 32'h0000_2058},   // B into invalid way 1
        '{1'b0, 1'b0, 32'h0000_2050},
        '{1'b0, 1'b1, 32'h0000_3054},   // C, victim bit 0 so way 0 goes
        '{1'b0, 1'b0, 32'h0000_2054},   // B still there
        '{1'b0, 1'b1, 32'h0000_105C},   // A again, victim bit 1 evicts B
        '{1'b0, 1'b0, 32'h0000_3050},
        '{1'b0, 1'b1, 32'h0000_4050},   // D, evicts C in way 0
        '{1'b0, 1'b0, 32'h0000_1050},
        '{1'b0, 1'b1, 32'h0001_0458},   // upper half of the sets
        '{1'b0, 1'b1, 32'h0002_0454},
        '{1'b0, 1'b0, 32'h0001_045C},
        '{1'b0, 1'b0, 32'h0002_0450},
        '{1'b1, 1'b1, 32'h0000_1050},   // reset drops every line
        '{1'b0, 1'b1, 32'h0001_0458},
        '{1'b0, 1'b0, 32'h0001_0458},
        '{1'b0, 1'b1, 32'h0000_4058}
    };

    logic                 I_clk;
    logic                 I_rst;
    logic [addr_bits-1:0] cpu_addr;
    logic                 cpu_rd_req;
    logic [word_bits-1:0] cpu_inst;
    logic                 cpu_rvalid;
    logic [addr_bits-1:0] mem_addr;
    logic                 mem_arvalid;
    logic                 mem_arready;
    beat_t                mem_rdata;
    logic                 mem_rvalid;
    logic                 mem_rlast;

    int cycle_count = 0;
    int ar_count = 0;
    int check_count = 0;
    int err_count = 0;
    logic [addr_bits-1:0] ar_addr_last;

    icache_top icache_top_inst (
        .I_clk       (I_clk),
        .I_rst       (I_rst),
        .cpu_addr    (cpu_addr),
        .cpu_rd_req  (cpu_rd_req),
        .cpu_inst    (cpu_inst),
        .cpu_rvalid  (cpu_rvalid),
        .mem_addr    (mem_addr),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .mem_rdata   (mem_rdata),
        .mem_rvalid  (mem_rvalid),
        .mem_rlast   (mem_rlast)
    );

    // line memory behind the cache
    icache_axi_mem icache_axi_mem_inst (
        .I_clk       (I_clk),
        .I_rst       (I_rst),
        .mem_addr    (mem_addr),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .mem_rdata   (mem_rdata),
        .mem_rvalid  (mem_rvalid),
        .mem_rlast   (mem_rlast)
    );

    initial begin
        I_clk = 1'b0;
        forever #(clk_half) I_clk = ~I_clk;
    end

    ////////////////////////////////////////////////////////////
    // AR handshake count and watchdog
    ////////////////////////////////////////////////////////////

    always @(posedge I_clk) begin
        if (!I_rst && mem_arvalid && mem_arready) begin
            ar_count <= ar_count + 1;
            ar_addr_last <= mem_addr;
        end
    end

    always @(posedge I_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("run stopped after %0d cycles without finishing the table", cycle_count);
            $display("test failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // compare helpers
    ////////////////////////////////////////////////////////////

    task automatic compare_word(input string name, input logic [word_bits-1:0] got,
                                input logic [word_bits-1:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic expect_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic verify_line_addr(input string name, input logic [addr_bits-1:0] got,
                                    input logic [addr_bits-1:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic tally_count(input string name, input int got, input int exp);
        check_count++;
        if (got != exp) begin
            err_count++;
            $display("Error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic apply_reset();
        I_rst = 1'b1;
        cpu_rd_req = 1'b0;
        repeat (reset_cycles) @(negedge I_clk);
        I_rst = 1'b0;
    endtask

    // one fetch, held until cpu_rvalid, then released
    task automatic fetch_entry(input int idx);
        entry_t e;
        int ar_before;
        int waited;
        int errs_before;
        logic [word_bits-1:0] got_word;
        logic got_miss;
        e = stim_tbl[idx];
        errs_before = err_count;
        if (e.rst) begin
            apply_reset();
        end
        @(negedge I_clk);
        ar_before = ar_count;
        cpu_addr = e.addr;
        cpu_rd_req = 1'b1;
        waited = 0;
        do begin
            @(negedge I_clk);
            waited++;
        end while (!cpu_rvalid);
        got_word = cpu_inst;
        // keep the request through the rvalid edge
        @(negedge I_clk);
        // rvalid is a one-cycle pulse
        expect_flag("cpu_rvalid", cpu_rvalid, 1'b0);
        cpu_rd_req = 1'b0;
        got_miss = (ar_count != ar_before);
        compare_word("cpu_inst", got_word, {e.addr[addr_bits-1:2], 2'b00} ^ content_key);
        expect_flag("miss", got_miss, e.miss);
        if (ar_count - ar_before > 1) begin
            err_count++;
            $display("entry %0d issued %0d read bursts for one miss", idx, ar_count - ar_before);
        end
        if (got_miss) begin
            verify_line_addr("mem_addr", ar_addr_last, {e.addr[addr_bits-1:offset_bits], 4'h0});
        end
        if (!e.miss && waited != 1) begin
            err_count++;
            $display("entry %0d hit took %0d cycles instead of one", idx, waited);
        end
        $display("entry %0d addr %h miss %0b cycles %0d %s", idx, e.addr, got_miss, waited,
                 (err_count == errs_before) ? "ok" : "mismatch");
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int exp_misses;
        I_rst = 1'b1;
        cpu_addr = '0;
        cpu_rd_req = 1'b0;
        exp_misses = 0;
        apply_reset();
        for (int i = 0; i < num_tests; i++) begin
            fetch_entry(i);
            if (stim_tbl[i].miss) begin
                exp_misses++;
            end
        end
        tally_count("ar_count", ar_count, exp_misses);
        $display("checks %0d errors %0d ar handshakes %0d", check_count, err_count, ar_count);
        if (err_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/icache_checker.sv */
`default_nettype none

module icache_checker (
    input wire logic                                      I_clk,
    input wire logic                                      I_rst,
    input wire logic                                      cpu_rd_req,
    input wire logic                                      cpu_rvalid,
    input wire logic [icache_geometry_pkg::addr_bits-1:0] mem_addr,
    input wire logic                                      mem_arvalid,
    input wire logic                                      mem_arready
);
    timeunit 1ns;
    timeprecision 100ps;

    // request held with a steady address through back-pressure
    ar_hold: assert property (@(posedge I_clk) disable iff (I_rst)
        (mem_arvalid && !mem_arready) |=> (mem_arvalid && $stable(mem_addr)))
        else $error("mem_arvalid dropped or mem_addr moved before mem_arready");

    // a returned word always answers a pending fetch
    rvalid_needs_req: assert property (@(posedge I_clk) disable iff (I_rst)
        cpu_rvalid |-> cpu_rd_req)
        else $error("cpu_rvalid high while cpu_rd_req is low");

    // no read issued straight out of reset
    arvalid_after_reset: assert property (@(posedge I_clk)
        I_rst |=> !mem_arvalid)
        else $error("mem_arvalid high in the cycle after reset");

endmodule

bind icache_top icache_checker icache_checker_inst (
    .I_clk       (I_clk),
    .I_rst       (I_rst),
    .cpu_rd_req  (cpu_rd_req),
    .cpu_rvalid  (cpu_rvalid),
    .mem_addr    (mem_addr),
    .mem_arvalid (mem_arvalid),
    .mem_arready (mem_arready)
);

`default_nettype wire

/* verification/icache_axi_mem.sv */
`default_nettype none

module icache_axi_mem (
    input wire logic                                      I_clk,
    input wire logic                                      I_rst,
    input wire logic [icache_geometry_pkg::addr_bits-1:0] mem_addr,
    input wire logic                                      mem_arvalid,
    output logic                                          mem_arready,
    output axi_read_pkg::beat_t                           mem_rdata,
    output logic                                          mem_rvalid,
    output logic                                          mem_rlast
);
    timeunit 1ns;
    timeprecision 100ps;
    import icache_geometry_pkg::*;
    import axi_read_pkg::*;

    // word at byte address A holds A ^ key
    localparam logic [word_bits-1:0] content_key = 32'h5A5A_0000;
    localparam int beat_bytes = 1 << beat_size_code;
    localparam int words_per_beat = beat_bytes / 4;

    // model phases
    localparam int ph_idle  = 0;
    localparam int ph_wait  = 1;
    localparam int ph_ready = 2;
    localparam int ph_data  = 3;

    int seed;
    int phase;
    int wait_left;
    int beat_idx;
    logic [addr_bits-1:0] line_addr;

    // one beat of the line, low words first
    function automatic beat_t beat_content(input logic [addr_bits-1:0] base, input int beat);
        beat_t d;
        logic [addr_bits-1:0] a;
        d = '0;
        for (int w = 0; w < words_per_beat; w++) begin
            a = base + beat * beat_bytes + w * 4;
            d[w*word_bits +: word_bits] = a ^ content_key;
        end
        return d;
    endfunction

    initial begin
        seed = 94;
        phase = ph_idle;
        mem_arready = 1'b0;
        mem_rdata = '0;
        mem_rvalid = 1'b0;
        mem_rlast = 1'b0;
    end

    ////////////////////////////////////////////////////////////
    // AR accept and beat return on the falling edge
    ////////////////////////////////////////////////////////////

    always @(negedge I_clk) begin
        if (I_rst) begin
            mem_arready <= 1'b0;
            mem_rvalid <= 1'b0;
            mem_rlast <= 1'b0;
            phase = ph_idle;
        end else begin
            case (phase)
                ph_idle: begin
                    if (mem_arvalid) begin
                        // back-pressure of 0 to 3 cycles
                        wait_left = $random(seed) & 3;
                        line_addr = mem_addr;
                        if (wait_left == 0) begin
                            mem_arready <= 1'b1;
                            phase = ph_ready;
                        end else begin
                            phase = ph_wait;
                        end
                    end
                end
                ph_wait: begin
                    wait_left = wait_left - 1;
                    if (wait_left == 0) begin
                        mem_arready <= 1'b1;
                        phase = ph_ready;
                    end
                end
                ph_ready: begin
                    // handshake done on the last rising edge
                    mem_arready <= 1'b0;
                    mem_rdata <= beat_content(line_addr, 0);
                    mem_rvalid <= 1'b1;
                    mem_rlast <= (burst_beats == 1);
                    beat_idx = 1;
                    phase = ph_data;
                end
                default: begin
                    if (beat_idx < burst_beats) begin
                        mem_rdata <= beat_content(line_addr, beat_idx);
                        mem_rlast <= (beat_idx == burst_beats - 1);
                        beat_idx = beat_idx + 1;
                    end else begin
                        mem_rvalid <= 1'b0;
                        mem_rlast <= 1'b0;
                        phase = ph_idle;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/icache_top.sv */
`default_nettype none

module icache_top (
    input wire logic                                  I_clk,
    input wire logic                                  I_rst,
    // cpu fetch port
    input wire logic [icache_geometry_pkg::addr_bits-1:0] cpu_addr,
    input wire logic                                  cpu_rd_req,
    output logic [icache_geometry_pkg::word_bits-1:0] cpu_inst,
    output logic                                      cpu_rvalid,
    // memory read port
    output logic [icache_geometry_pkg::addr_bits-1:0] mem_addr,
    output logic                                      mem_arvalid,
    input wire logic                                  mem_arready,
    input wire axi_read_pkg::beat_t                   mem_rdata,
    input wire logic                                  mem_rvalid,
    input wire logic                                  mem_rlast
);

    // controller to bank group
    icache_sram_if sram_bus ();
    // controller to tag store
    icache_tag_if tag_bus ();

    // miss fsm and bank decode
    icache_ctrl icache_ctrl_inst (
        .I_clk       (I_clk),
        .I_rst       (I_rst),
        .cpu_addr    (cpu_addr),
        .cpu_rd_req  (cpu_rd_req),
        .cpu_inst    (cpu_inst),
        .cpu_rvalid  (cpu_rvalid),
        .mem_addr    (mem_addr),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .mem_rdata   (mem_rdata),
        .mem_rvalid  (mem_rvalid),
        .mem_rlast   (mem_rlast),
        .tag         (tag_bus.ctrl),
        .sram        (sram_bus.ctrl)
    );

    // tags, valid and victim bits
    icache_tag_store icache_tag_store_inst (
        .I_clk (I_clk),
        .I_rst (I_rst),
        .tag   (tag_bus.store)
    );

    // four line banks
    icache_data_sram icache_data_sram_inst (
        .I_clk (I_clk),
        .sram  (sram_bus.array)
    );

endmodule

`default_nettype wire

/* logic/icache_ctrl.sv */
`default_nettype none

module icache_ctrl (
    input wire logic                                  I_clk,
    input wire logic                                  I_rst,
    // cpu fetch side
    input wire icache_geometry_pkg::fetch_addr_t      cpu_addr,
    input wire logic                                  cpu_rd_req,
    output logic [icache_geometry_pkg::word_bits-1:0] cpu_inst,
    output logic                                      cpu_rvalid,
    // memory read side
    output logic [icache_geometry_pkg::addr_bits-1:0] mem_addr,
    output logic                                      mem_arvalid,
    input wire logic                                  mem_arready,
    input wire axi_read_pkg::beat_t                   mem_rdata,
    input wire logic                                  mem_rvalid,
    input wire logic                                  mem_rlast,
    // tag store and data banks
    icache_tag_if.ctrl                                tag,
    icache_sram_if.ctrl                               sram
);
    import icache_geometry_pkg::*;
    import axi_read_pkg::*;

    // fsm codes
    localparam logic [2:0] st_idle   = 3'd0;
    localparam logic [2:0] st_hit    = 3'd1;
    localparam logic [2:0] st_miss   = 3'd2;
    localparam logic [2:0] st_reload = 3'd3;
    localparam logic [2:0] st_alloc  = 3'd4;

    localparam int cnt_bits = $clog2(burst_beats);

    logic [2:0]          state;
    logic [2:0]          state_nxt;
    // request address, latched when accepted
    fetch_addr_t         req_addr;
    // refill buffer
    line_t               line_buf;
    logic [cnt_bits-1:0] beat_cnt;
    logic                accept;
    logic                lookup_hit;
    logic                alloc;
    line_t               line_src;

    ////////////////////////////////////////////////////////////
    // lookup and state machine
    ////////////////////////////////////////////////////////////

    assign tag.lookup_index = cpu_addr.f.index;
    assign tag.lookup_tag   = cpu_addr.f.tag;

    assign accept     = (state == st_idle) && cpu_rd_req;
    assign lookup_hit = tag.way0_hit || tag.way1_hit;
    assign alloc      = (state == st_alloc);

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (accept) begin
                    state_nxt = lookup_hit ? st_hit : st_miss;
                end
            end
            // word comes out, then one idle cycle
            st_hit: state_nxt = st_idle;
            // hold arvalid until the handshake
            st_miss: begin
                if (mem_arready) begin
                    state_nxt = st_reload;
                end
            end
            st_reload: begin
                if (mem_rvalid && mem_rlast) begin
                    state_nxt = st_alloc;
                end
            end
            st_alloc: state_nxt = st_idle;
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // address stays put for the whole miss
    always_ff @(posedge I_clk) begin
        if (accept) begin
            req_addr <= cpu_addr;
        end
    end

    ////////////////////////////////////////////////////////////
    // memory read and refill
    ////////////////////////////////////////////////////////////

    // line aligned burst address
    assign mem_addr    = {req_addr.word[addr_bits-1:offset_bits], {offset_bits{1'b0}}};
    assign mem_arvalid = (state == st_miss);

    // beat counter restarts outside reload
    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            beat_cnt <= '0;
        end else if (state != st_reload) begin
            beat_cnt <= '0;
        end else if (mem_rvalid) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // beats land in order, low half first
    always_ff @(posedge I_clk) begin
        if ((state == st_reload) && mem_rvalid) begin
            line_buf[beat_cnt*beat_bits +: beat_bits] <= mem_rdata;
        end
    end

    // tag fill in the allocate cycle
    assign tag.fill       = alloc;
    assign tag.fill_index = req_addr.f.index;
    assign tag.fill_tag   = req_addr.f.tag;

    ////////////////////////////////////////////////////////////
    // bank access
    ////////////////////////////////////////////////////////////

    // bank index is {top index bit, way}
    always_comb begin
        sram.cen = '1;
        if (accept && lookup_hit) begin
            sram.cen[{cpu_addr.f.index[index_bits-1], tag.way1_hit}] = 1'b0;
        end else if (alloc) begin
            sram.cen[{req_addr.f.index[index_bits-1], tag.victim_way}] = 1'b0;
        end
    end

    assign sram.addr = alloc ? req_addr.f.index[bank_addr_bits-1:0]
                             : cpu_addr.f.index[bank_addr_bits-1:0];
    // whole line written on allocate
    assign sram.wen   = ~alloc;
    assign sram.wmask = alloc ? '0 : '1;
    assign sram.wdata = line_buf;

    // word out of the bank on a hit, out of the buffer on allocate
    assign line_src   = alloc ? line_buf : sram.rdata;
    assign cpu_inst   = line_src[req_addr.f.word_sel*word_bits +: word_bits];
    assign cpu_rvalid = (state == st_hit) || alloc;

endmodule

`default_nettype wire

/* logic/icache_data_sram.sv */
`default_nettype none

module icache_data_sram (
    input wire logic     I_clk,
    icache_sram_if.array sram
);
    import icache_geometry_pkg::*;

    // registered read line of each bank
    line_t bank_rd [num_banks];
    // banks read last cycle, one-hot
    logic [num_banks-1:0] rd_sel;

    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        // 64 lines per bank
        line_t mem [bank_depth];
        line_t rd_q;

        always_ff @(posedge I_clk) begin
            if (!sram.cen[b]) begin
                if (!sram.wen) begin
                    // keep bits with mask high
                    mem[sram.addr] <= (mem[sram.addr] & sram.wmask)
                                      | (sram.wdata & ~sram.wmask);
                end else begin
                    rd_q <= mem[sram.addr];
                end
            end
        end

        assign bank_rd[b] = rd_q;
    end

    // remember which bank a read went to
    always_ff @(posedge I_clk) begin
        if (sram.wen && (sram.cen != '1)) begin
            rd_sel <= ~sram.cen;
        end
    end

    // or-mux over the one-hot select
    always_comb begin
        sram.rdata = '0;
        for (int b = 0; b < num_banks; b++) begin
            if (rd_sel[b]) begin
                sram.rdata = sram.rdata | bank_rd[b];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/icache_tag_store.sv */
`default_nettype none

module icache_tag_store (
    input wire logic   I_clk,
    input wire logic   I_rst,
    icache_tag_if.store tag
);
    import icache_geometry_pkg::*;

    // tag per way and set
    logic [tag_bits-1:0] tag_tbl [num_ways][num_sets];
    // valid per way, one bit per set
    logic [num_sets-1:0] valid_tbl [num_ways];
    // per-set victim bit, flips on each fill
    logic [num_sets-1:0] victim_bits;

    logic fill_v0;
    logic fill_v1;

    ////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////

    // hit needs valid and tag match
    assign tag.way0_hit = valid_tbl[0][tag.lookup_index]
                          && (tag_tbl[0][tag.lookup_index] == tag.lookup_tag);
    assign tag.way1_hit = valid_tbl[1][tag.lookup_index]
                          && (tag_tbl[1][tag.lookup_index] == tag.lookup_tag);

    // state of the set being filled
    assign fill_v0 = valid_tbl[0][tag.fill_index];
    assign fill_v1 = valid_tbl[1][tag.fill_index];

    // invalid way first, way 0 before way 1
    always_comb begin
        if (!fill_v0) begin
            tag.victim_way = 1'b0;
        end else if (!fill_v1) begin
            tag.victim_way = 1'b1;
        end else begin
            // both valid, follow the victim bit
            tag.victim_way = victim_bits[tag.fill_index];
        end
    end

    ////////////////////////////////////////////////////////////
    // fill
    ////////////////////////////////////////////////////////////

    // tag write into the chosen way
    always_ff @(posedge I_clk) begin
        if (tag.fill) begin
            tag_tbl[tag.victim_way][tag.fill_index] <= tag.fill_tag;
        end
    end

    // valid and victim bits
    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            for (int w = 0; w < num_ways; w++) begin
                valid_tbl[w] <= '0;
            end
            victim_bits <= '0;
        end else if (tag.fill) begin
            valid_tbl[tag.victim_way][tag.fill_index] <= 1'b1;
            // toggles on every fill of the set
            victim_bits[tag.fill_index] <= ~victim_bits[tag.fill_index];
        end
    end

endmodule

`default_nettype wire

/* logic/icache_tag_if.sv */
`default_nettype none

interface icache_tag_if;
    import icache_geometry_pkg::*;

    // lookup from the cpu request
    logic [index_bits-1:0] lookup_index;
    logic [tag_bits-1:0]   lookup_tag;
    logic                  way0_hit;
    logic                  way1_hit;

    // line fill on allocate
    logic                  fill;
    logic [index_bits-1:0] fill_index;
    logic [tag_bits-1:0]   fill_tag;
    // way to replace at fill_index
    logic                  victim_way;

    modport ctrl (output lookup_index, lookup_tag, fill, fill_index, fill_tag,
                  input way0_hit, way1_hit, victim_way);
    modport store (input lookup_index, lookup_tag, fill, fill_index, fill_tag,
                   output way0_hit, way1_hit, victim_way);

endinterface

`default_nettype wire

/* logic/icache_sram_if.sv */
`default_nettype none

interface icache_sram_if;
    import icache_geometry_pkg::*;

    // shared address for the whole bank group
    logic [bank_addr_bits-1:0] addr;
    // one active-low enable per bank
    logic [num_banks-1:0]      cen;
    // low means write
    logic                      wen;
    line_t                     wdata;
    // zero mask bits are written
    line_t                     wmask;
    // valid one cycle after a read access
    line_t                     rdata;

    modport ctrl (output addr, cen, wen, wdata, wmask, input rdata);
    modport array (input addr, cen, wen, wdata, wmask, output rdata);

endinterface

`default_nettype wire

/* logic/axi_read_pkg.sv */
`default_nettype none

package axi_read_pkg;

    // one read beat on the memory port
    localparam int beat_bits = 64;

    // beats per line fill
    // low half of the line arrives first
    localparam int burst_beats = 2;

    // size code for 8-byte beats
    localparam logic [2:0] beat_size_code = 3'b011;

    typedef logic [beat_bits-1:0] beat_t;

endpackage

`default_nettype wire

/* logic/icache_geometry_pkg.sv */
`default_nettype none

package icache_geometry_pkg;

    // fetch address split
    localparam int offset_bits = 4;
    localparam int index_bits = 7;
    localparam int tag_bits = 21;
    localparam int addr_bits = tag_bits + index_bits + offset_bits;

    // two ways of 128 sets
    localparam int num_ways = 2;
    localparam int num_sets = 1 << index_bits;

    // bank = {top index bit, way}
    localparam int num_banks = 4;
    localparam int bank_depth = 64;
    localparam int bank_addr_bits = 6;

    // line and instruction widths
    localparam int line_bits = 128;
    localparam int word_bits = 32;

    typedef logic [line_bits-1:0] line_t;

    // whole word for the bus, fields for the lookup
    typedef union packed {
        logic [addr_bits-1:0] word;
        struct packed {
            logic [tag_bits-1:0]      tag;
            logic [index_bits-1:0]    index;
            logic [offset_bits-3:0]   word_sel;
            logic [1:0]               byte_sel;
        } f;
    } fetch_addr_t;

endpackage

`default_nettype wire
